//--- design/addr_consts.svh
//----------------------------------------------------------
// Widths and sizes of the operand address translation stage
// The indirect window must be aligned to PO_ENTRY_COUNT words
// PO_ENTRY_COUNT must equal 2**PO_INDEX_WIDTH
//----------------------------------------------------------

`ifndef ADDR_CONSTS_SVH
`define ADDR_CONSTS_SVH

// Raw, offset and final address width
`define ADDR_WIDTH          10

// Barrel threading
`define THREAD_COUNT        4
`define THREAD_WIDTH        2

// Programmed offset entries per thread
`define PO_ENTRY_COUNT      4
`define PO_INDEX_WIDTH      2

// Increment field is sign plus magnitude
`define PO_INCR_WIDTH       4
`define PO_ENTRY_WIDTH      14

// First word of the indirect window
`define ADDR_INDIRECT_BASE  10'h3F0

// Register stages from raw_addr to the combined offsets
`define PIPE_DEPTH          2

`endif

//--- design/addr_pkg.sv
//----------------------------------------------------------
// Address and programmed offset entry types
// Entry layout from the top is sign, magnitude, offset
//----------------------------------------------------------

`include "addr_consts.svh"

package addr_pkg;

    // One address word, raw or translated
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Packed programmed offset entry
    // Bit PO_ENTRY_WIDTH-1 holds the increment sign
    // The increment magnitude sits just below the sign
    // The offset fills the low ADDR_WIDTH bits
    // An all-zero increment field gives a plain pointer
    typedef logic [`PO_ENTRY_WIDTH-1:0] po_entry_t;

    // Increment magnitude, without the sign bit
    // Signed-magnitude keeps the step range symmetric
    typedef logic [`PO_INCR_WIDTH-2:0] pi_mag_t;

endpackage

//--- design/thread_pkg.sv
//----------------------------------------------------------
// Thread number and entry index types
// Entry index comes from the raw address low bits
//----------------------------------------------------------

`include "addr_consts.svh"

package thread_pkg;

    // Barrel thread number
    // Selects the per-thread bank of every memory
    typedef logic [`THREAD_WIDTH-1:0] thread_t;

    // Index of one programmed offset entry within a thread
    // Concatenated below the thread number to form a RAM address
    typedef logic [`PO_INDEX_WIDTH-1:0] po_index_t;

endpackage

//--- design/po_write_if.sv
//----------------------------------------------------------
// External programmed offset write with its annul flags
// The write has no acknowledge and lands at the next edge
//----------------------------------------------------------

`timescale 1ns/1ps

interface po_write_if;

    // Write strobe from the previous instruction
    logic                   wren;
    thread_pkg::po_index_t  write_index;
    addr_pkg::po_entry_t    write_data;

    // Annul state of the instruction that issued the write
    logic                   io_ready_previous;
    logic                   cancel_previous;

    // Driven by the top from its plain ports
    modport source (
        output wren,
        output write_index,
        output write_data,
        output io_ready_previous,
        output cancel_previous
    );

    // Consumed by the programmed offset memory
    modport sink (
        input wren,
        input write_index,
        input write_data,
        input io_ready_previous,
        input cancel_previous
    );

endinterface

//--- design/po_memory.sv
//----------------------------------------------------------
// Programmed offset and increment RAM with post-increment
// Read during write to one location returns the old entry
// Entries are undefined until written
//----------------------------------------------------------

`timescale 1ns/1ps

`include "addr_consts.svh"

module po_memory (
    input  logic                    clock,
    input  logic                    arst_n,
    input  thread_pkg::thread_t     read_thread,
    input  thread_pkg::thread_t     write_thread,
    input  thread_pkg::po_index_t   read_index,
    input  logic                    po_incr_enable,
    input  logic                    io_ready_current,
    input  logic                    cancel_current,
    po_write_if.sink                wr,
    output addr_pkg::addr_t         programmed_offset
);

    localparam int RAM_DEPTH      = `THREAD_COUNT * `PO_ENTRY_COUNT;
    localparam int RAM_ADDR_WIDTH = `THREAD_WIDTH + `PO_INDEX_WIDTH;

    // Thread number in the high address bits
    addr_pkg::po_entry_t        ram [RAM_DEPTH];
    logic [RAM_ADDR_WIDTH-1:0]  ram_read_addr;
    logic [RAM_ADDR_WIDTH-1:0]  ram_write_addr;
    addr_pkg::po_entry_t        ram_read_data;

    // Write-back index, aligned with write_thread
    thread_pkg::po_index_t      index_pipe [`PIPE_DEPTH];

    // Unpacked fields of the entry read in stage 1
    logic                       pi_sign;
    addr_pkg::pi_mag_t          pi_mag;
    addr_pkg::addr_t            po_raw;
    addr_pkg::addr_t            po_post;
    addr_pkg::po_entry_t        incr_entry;
    addr_pkg::po_entry_t        incr_entry_q;

    // Write port arbitration
    logic                       ext_grant;
    logic                       int_grant;
    logic                       ext_wren;
    logic                       int_wren;
    logic                       ram_wren;
    thread_pkg::po_index_t      write_index_sel;
    addr_pkg::po_entry_t        write_data_sel;

    //----------------------------------------------------------
    // Stage 0, read address
    //----------------------------------------------------------

    assign ram_read_addr = {read_thread, read_index};

    // Index travels with the access until write-back
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                index_pipe[i] <= '0;
            end
        end else begin
            index_pipe[0] <= read_index;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                index_pipe[i] <= index_pipe[i-1];
            end
        end
    end

    //----------------------------------------------------------
    // Write arbitration
    //----------------------------------------------------------

    // External write wins the port whenever it is requested
    // A masked external write still blocks the increment
    assign ext_grant = wr.wren;
    assign int_grant = po_incr_enable & ~wr.wren;

    // Each source is annulled by its own instruction's flags
    assign ext_wren = ext_grant & wr.io_ready_previous & ~wr.cancel_previous;
    assign int_wren = int_grant & io_ready_current & ~cancel_current;
    assign ram_wren = ext_wren | int_wren;

    assign write_index_sel = ext_grant ? wr.write_index : index_pipe[`PIPE_DEPTH-1];
    assign write_data_sel  = ext_grant ? wr.write_data  : incr_entry_q;

    // Both sources write into the bank of write_thread
    assign ram_write_addr = {write_thread, write_index_sel};

    // Simple dual port RAM, registered read
    always_ff @(posedge clock) begin
        if (ram_wren) begin
            ram[ram_write_addr] <= write_data_sel;
        end
        ram_read_data <= ram[ram_read_addr];
        incr_entry_q  <= incr_entry;
    end

    //----------------------------------------------------------
    // Stage 1, post-increment
    //----------------------------------------------------------

    assign pi_sign = ram_read_data[`PO_ENTRY_WIDTH-1];
    assign pi_mag  = ram_read_data[`ADDR_WIDTH +: `PO_INCR_WIDTH-1];
    assign po_raw  = ram_read_data[`ADDR_WIDTH-1:0];

    // Sign 0 steps up, sign 1 steps down, wrapping at the word size
    assign po_post = pi_sign ? (po_raw - addr_pkg::addr_t'(pi_mag))
                             : (po_raw + addr_pkg::addr_t'(pi_mag));

    // Increment field is written back unchanged
    assign incr_entry = {pi_sign, pi_mag, po_post};

    // Offset before the increment is what this access uses
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            programmed_offset <= '0;
        end else begin
            programmed_offset <= po_raw;
        end
    end

endmodule

//--- design/default_offset_memory.sv
//----------------------------------------------------------
// One default base offset per thread
// Writes are never annulled and land at the next edge
//----------------------------------------------------------

`timescale 1ns/1ps

`include "addr_consts.svh"

module default_offset_memory (
    input  logic                    clock,
    input  logic                    arst_n,
    input  thread_pkg::thread_t     read_thread,
    input  thread_pkg::thread_t     write_thread,
    input  logic                    do_wren,
    input  addr_pkg::addr_t         do_write_data,
    output addr_pkg::addr_t         default_offset
);

    // Per-thread base offsets
    addr_pkg::addr_t offset_regs [`THREAD_COUNT];

    // First stage is the register read, the rest align with the RAM
    addr_pkg::addr_t read_pipe [`PIPE_DEPTH];

    //----------------------------------------------------------
    // Offset registers
    //----------------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < `THREAD_COUNT; t++) begin
                offset_regs[t] <= '0;
            end
        end else if (do_wren) begin
            offset_regs[write_thread] <= do_write_data;
        end
    end

    //----------------------------------------------------------
    // Read pipeline
    //----------------------------------------------------------

    // Old value is seen when a read meets a write to the same thread
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                read_pipe[i] <= '0;
            end
        end else begin
            read_pipe[0] <= offset_regs[read_thread];
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                read_pipe[i] <= read_pipe[i-1];
            end
        end
    end

    // Valid in the same cycle as programmed_offset
    assign default_offset = read_pipe[`PIPE_DEPTH-1];

endmodule

//--- design/address_translator.sv
//----------------------------------------------------------
// Indirect window decode and final address combination
// Sums wrap modulo 2**ADDR_WIDTH
//----------------------------------------------------------

`timescale 1ns/1ps

`include "addr_consts.svh"

module address_translator (
    input  logic                    clock,
    input  logic                    arst_n,
    input  addr_pkg::addr_t         raw_addr,
    output thread_pkg::po_index_t   read_index,
    output logic                    po_incr_enable,
    input  addr_pkg::addr_t         programmed_offset,
    input  addr_pkg::addr_t         default_offset,
    output addr_pkg::addr_t         final_addr
);

    // Window is aligned, so only the bits above the index compare
    localparam addr_pkg::addr_t WINDOW_BASE = `ADDR_INDIRECT_BASE;
    localparam int              WINDOW_LSB  = `PO_INDEX_WIDTH;

    logic               indirect;
    logic               indirect_pipe [`PIPE_DEPTH];
    addr_pkg::addr_t    raw_pipe [`PIPE_DEPTH];
    addr_pkg::addr_t    base_sel;

    //----------------------------------------------------------
    // Decode
    //----------------------------------------------------------

    assign indirect = (raw_addr[`ADDR_WIDTH-1:WINDOW_LSB] ==
                       WINDOW_BASE[`ADDR_WIDTH-1:WINDOW_LSB]);

    // Low bits pick the entry, used for direct accesses too
    assign read_index = raw_addr[`PO_INDEX_WIDTH-1:0];

    // Delay to meet the offsets, reset to a direct access
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                indirect_pipe[i] <= 1'b0;
                raw_pipe[i]      <= '0;
            end
        end else begin
            indirect_pipe[0] <= indirect;
            raw_pipe[0]      <= raw_addr;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                indirect_pipe[i] <= indirect_pipe[i-1];
                raw_pipe[i]      <= raw_pipe[i-1];
            end
        end
    end

    //----------------------------------------------------------
    // Combine
    //----------------------------------------------------------

    // Increment request lines up with the entry's write-back cycle
    assign po_incr_enable = indirect_pipe[`PIPE_DEPTH-1];

    assign base_sel = po_incr_enable ? programmed_offset : raw_pipe[`PIPE_DEPTH-1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            final_addr <= '0;
        end else begin
            final_addr <= base_sel + default_offset;
        end
    end

endmodule

//--- design/address_module.sv
//----------------------------------------------------------
// Operand address translation, fixed 3-cycle latency
// write_thread must be read_thread from two cycles earlier
// No stall, one access enters every cycle
//----------------------------------------------------------

`timescale 1ns/1ps

module address_module (
    input  logic                    clock,
    input  logic                    arst_n,
    input  addr_pkg::addr_t         raw_addr,
    input  thread_pkg::thread_t     read_thread,
    input  thread_pkg::thread_t     write_thread,
    // Annul flags of the instruction two cycles back
    input  logic                    io_ready_current,
    input  logic                    cancel_current,
    // External programmed offset write
    input  logic                    po_wren,
    input  thread_pkg::po_index_t   po_write_index,
    input  addr_pkg::po_entry_t     po_write_data,
    input  logic                    io_ready_previous,
    input  logic                    cancel_previous,
    // Default offset write
    input  logic                    do_wren,
    input  addr_pkg::addr_t         do_write_data,
    output addr_pkg::addr_t         final_addr
);

    thread_pkg::po_index_t  read_index;
    logic                   po_incr_enable;
    addr_pkg::addr_t        programmed_offset;
    addr_pkg::addr_t        default_offset;

    po_write_if po_wr ();

    // Bundle the external write for the RAM
    assign po_wr.wren              = po_wren;
    assign po_wr.write_index       = po_write_index;
    assign po_wr.write_data        = po_write_data;
    assign po_wr.io_ready_previous = io_ready_previous;
    assign po_wr.cancel_previous   = cancel_previous;

    address_translator u_address_translator (
        .clock              (clock),
        .arst_n             (arst_n),
        .raw_addr           (raw_addr),
        .read_index         (read_index),
        .po_incr_enable     (po_incr_enable),
        .programmed_offset  (programmed_offset),
        .default_offset     (default_offset),
        .final_addr         (final_addr)
    );

    po_memory u_po_memory (
        .clock              (clock),
        .arst_n             (arst_n),
        .read_thread        (read_thread),
        .write_thread       (write_thread),
        .read_index         (read_index),
        .po_incr_enable     (po_incr_enable),
        .io_ready_current   (io_ready_current),
        .cancel_current     (cancel_current),
        .wr                 (po_wr.sink),
        .programmed_offset  (programmed_offset)
    );

    default_offset_memory u_default_offset_memory (
        .clock              (clock),
        .arst_n             (arst_n),
        .read_thread        (read_thread),
        .write_thread       (write_thread),
        .do_wren            (do_wren),
        .do_write_data      (do_write_data),
        .default_offset     (default_offset)
    );

endmodule

//--- bench/address_module_assert.sv
//----------------------------------------------------------
// Concurrent checks bound onto the translation top
// Checks the caller's write_thread rule, does not enforce it
//----------------------------------------------------------

`timescale 1ns/1ps

`include "addr_consts.svh"

module address_module_assert (
    input logic                 clock,
    input logic                 arst_n,
    input addr_pkg::addr_t      raw_addr,
    input thread_pkg::thread_t  read_thread,
    input thread_pkg::thread_t  write_thread,
    input logic                 po_incr_enable,
    input addr_pkg::addr_t      final_addr
);

    localparam addr_pkg::addr_t WINDOW_BASE = `ADDR_INDIRECT_BASE;

    logic raw_direct;

    // Outside the indirect window
    assign raw_direct = (raw_addr < WINDOW_BASE) ||
                        (raw_addr >= WINDOW_BASE + `PO_ENTRY_COUNT);

    // Write-back goes to the bank that was read
    write_thread_aligned: assert property (@(posedge clock) disable iff (!arst_n)
        write_thread == $past(read_thread, 2))
        else $error("write_thread is not the read_thread of two cycles back");

    final_addr_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(final_addr))
        else $error("final_addr holds unknown bits");

    incr_only_indirect: assert property (@(posedge clock) disable iff (!arst_n)
        $past(raw_direct, 2) |-> !po_incr_enable)
        else $error("po_incr_enable high for a direct access");

endmodule

bind address_module address_module_assert u_address_module_assert (
    .clock          (clock),
    .arst_n         (arst_n),
    .raw_addr       (raw_addr),
    .read_thread    (read_thread),
    .write_thread   (write_thread),
    .po_incr_enable (po_incr_enable),
    .final_addr     (final_addr)
);

//--- bench/address_module_tb.sv
//----------------------------------------------------------
// Directed testbench for the operand address translation
// Model follows RAM timing per cycle, old data on collision
// Indirect accesses only target entries written beforehand
//----------------------------------------------------------

`timescale 1ns/1ps

`include "addr_consts.svh"

module address_module_tb;

    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = 400;
    localparam int RAM_DEPTH       = `THREAD_COUNT * `PO_ENTRY_COUNT;
    localparam addr_pkg::addr_t WINDOW_BASE = `ADDR_INDIRECT_BASE;

    // One access in flight, slot 0 newest, slot 3 due for checking
    typedef struct packed {
        logic                   valid;
        logic                   indirect;
        logic                   rdy;
        logic                   cncl;
        thread_pkg::thread_t    thr;
        thread_pkg::po_index_t  idx;
        addr_pkg::po_entry_t    entry;
        addr_pkg::addr_t        expect_addr;
    } slot_t;

    logic                   clock, arst_n;
    addr_pkg::addr_t        raw_addr, do_write_data, final_addr;
    thread_pkg::thread_t    read_thread, write_thread;
    logic                   io_ready_current, cancel_current;
    logic                   po_wren, io_ready_previous, cancel_previous, do_wren;
    thread_pkg::po_index_t  po_write_index;
    addr_pkg::po_entry_t    po_write_data;

    // Reference state
    addr_pkg::po_entry_t    ram_model [RAM_DEPTH];
    logic                   ram_known [RAM_DEPTH];
    addr_pkg::addr_t        do_model [`THREAD_COUNT];
    slot_t                  slots [4];

    // Writes waiting for the next access cycle
    logic                   p_po_wren, p_po_rdy, p_po_cncl, p_do_wren;
    thread_pkg::po_index_t  p_po_idx;
    addr_pkg::po_entry_t    p_po_data;
    addr_pkg::addr_t        p_do_data;

    int seed = 32'h94e3;
    int check_count = 0;
    int error_count = 0;

    address_module u_address_module (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    //----------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------

    task automatic check_addr(input string sig, input addr_pkg::addr_t act,
                              input addr_pkg::addr_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic check_entry(input string sig, input addr_pkg::po_entry_t act,
                               input addr_pkg::po_entry_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic check_thread(input string sig, input thread_pkg::thread_t act,
                                input thread_pkg::thread_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, exp, act);
        end
    endtask

    //----------------------------------------------------------
    // Model helpers
    //----------------------------------------------------------

    // Offset moves by the signed magnitude, increment field kept
    function automatic addr_pkg::po_entry_t stepped(input addr_pkg::po_entry_t e);
        addr_pkg::pi_mag_t mag;
        addr_pkg::addr_t   off;
        mag = e[`PO_ENTRY_WIDTH-2 -: `PO_INCR_WIDTH-1];
        off = e[`PO_ENTRY_WIDTH-1] ? e[`ADDR_WIDTH-1:0] - mag : e[`ADDR_WIDTH-1:0] + mag;
        return {e[`PO_ENTRY_WIDTH-1 -: `PO_INCR_WIDTH], off};
    endfunction

    // Never reaches the window at 3F0
    function automatic addr_pkg::addr_t direct_addr();
        return addr_pkg::addr_t'($random(seed)) & 10'h1FF;
    endfunction

    function automatic addr_pkg::addr_t window_addr(input thread_pkg::po_index_t idx);
        return WINDOW_BASE + idx;
    endfunction

    //----------------------------------------------------------
    // Access cycle
    //----------------------------------------------------------

    task automatic issue_access(input addr_pkg::addr_t raw, input thread_pkg::thread_t thr,
                                input logic rdy = 1'b1, input logic cncl = 1'b0);
        @(posedge clock);
        #1;
        for (int i = 3; i > 0; i--) begin
            slots[i] = slots[i-1];
        end
        // Access from three cycles back is now in final_addr
        if (slots[3].valid) begin
            check_addr("final_addr", final_addr, slots[3].expect_addr);
            // RAM write bank used at the edge just passed
            check_thread("ram_write_addr thread",
                         thread_pkg::thread_t'(u_address_module.u_po_memory.ram_write_addr
                                               >> `PO_INDEX_WIDTH),
                         slots[3].thr);
        end
        // Read side sees writes up to the edge just passed
        slots[0].valid       = 1'b1;
        slots[0].thr         = thr;
        slots[0].rdy         = rdy;
        slots[0].cncl        = cncl;
        slots[0].indirect    = (raw >= WINDOW_BASE) && (raw < WINDOW_BASE + `PO_ENTRY_COUNT);
        slots[0].idx         = thread_pkg::po_index_t'(raw - WINDOW_BASE);
        slots[0].entry       = ram_model[{thr, slots[0].idx}];
        slots[0].expect_addr = (slots[0].indirect ? slots[0].entry[`ADDR_WIDTH-1:0] : raw)
                               + do_model[thr];
        // Write side of the access two back, external write first
        if (p_po_wren) begin
            if (p_po_rdy && !p_po_cncl) begin
                ram_model[{slots[2].thr, p_po_idx}] = p_po_data;
                ram_known[{slots[2].thr, p_po_idx}] = 1'b1;
            end
        end else if (slots[2].indirect && slots[2].rdy && !slots[2].cncl) begin
            ram_model[{slots[2].thr, slots[2].idx}] = stepped(slots[2].entry);
        end
        if (p_do_wren) begin
            do_model[slots[2].thr] = p_do_data;
        end
        raw_addr          = raw;
        read_thread       = thr;
        write_thread      = slots[2].thr;
        io_ready_current  = slots[2].rdy;
        cancel_current    = slots[2].cncl;
        po_wren           = p_po_wren;
        po_write_index    = p_po_idx;
        po_write_data     = p_po_data;
        io_ready_previous = p_po_rdy;
        cancel_previous   = p_po_cncl;
        do_wren           = p_do_wren;
        do_write_data     = p_do_data;
        p_po_wren         = 1'b0;
        p_do_wren         = 1'b0;
    endtask

    // Two fillers bring thr into the write-back slot
    task automatic write_entry(input thread_pkg::thread_t thr, input thread_pkg::po_index_t idx,
                               input addr_pkg::po_entry_t data, input logic rdy = 1'b1,
                               input logic cncl = 1'b0);
        issue_access(direct_addr(), thr);
        issue_access(direct_addr(), thr);
        p_po_wren = 1'b1;
        p_po_idx  = idx;
        p_po_data = data;
        p_po_rdy  = rdy;
        p_po_cncl = cncl;
        issue_access(direct_addr(), thr);
    endtask

    task automatic write_default(input thread_pkg::thread_t thr, input addr_pkg::addr_t val);
        issue_access(direct_addr(), thr);
        issue_access(direct_addr(), thr);
        p_do_wren = 1'b1;
        p_do_data = val;
        issue_access(direct_addr(), thr);
    endtask

    // Flush the pipeline, then compare every written entry
    task automatic drain_and_compare();
        repeat (3) issue_access(direct_addr(), 2'd0);
        for (int a = 0; a < RAM_DEPTH; a++) begin
            if (ram_known[a]) begin
                check_entry($sformatf("ram[%0d]", a), u_address_module.u_po_memory.ram[a],
                            ram_model[a]);
            end
        end
    endtask

    //----------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------

    task automatic test_direct();
        for (int i = 0; i < 8; i++) issue_access(direct_addr(), thread_pkg::thread_t'(i));
        write_default(2'd1, addr_pkg::addr_t'($random(seed)));
        for (int i = 0; i < 8; i++) issue_access(direct_addr(), thread_pkg::thread_t'(i));
        drain_and_compare();
    endtask

    // Zero increment keeps every pointer fixed
    task automatic test_indirect_read();
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            write_default(thread_pkg::thread_t'(t), addr_pkg::addr_t'($random(seed)));
            for (int i = 0; i < `PO_ENTRY_COUNT; i++) begin
                write_entry(thread_pkg::thread_t'(t), thread_pkg::po_index_t'(i),
                            {4'b0000, addr_pkg::addr_t'($random(seed))});
            end
        end
        for (int i = 0; i < 16; i++) begin
            issue_access(window_addr(thread_pkg::po_index_t'(i)), thread_pkg::thread_t'(i / 4));
        end
        drain_and_compare();
    endtask

    task automatic test_post_increment();
        write_entry(2'd0, 2'd1, {1'b0, 3'd5, 10'h3FC});
        write_entry(2'd1, 2'd1, {1'b1, 3'd2, 10'h003});
        write_entry(2'd2, 2'd1, {4'b0000, addr_pkg::addr_t'($random(seed))});
        write_entry(2'd3, 2'd1, {1'b1, 3'd7, addr_pkg::addr_t'($random(seed))});
        // Round robin keeps each thread clear of its own write-back
        for (int i = 0; i < 24; i++) issue_access(window_addr(2'd1), thread_pkg::thread_t'(i));
        drain_and_compare();
    endtask

    task automatic test_masking();
        write_entry(2'd2, 2'd3, {1'b0, 3'd3, addr_pkg::addr_t'($random(seed))});
        issue_access(window_addr(2'd3), 2'd2, 1'b1, 1'b1);
        issue_access(window_addr(2'd3), 2'd2, 1'b0, 1'b0);
        repeat (4) issue_access(window_addr(2'd3), 2'd2);
        // Annulled external writes
        write_entry(2'd2, 2'd3, addr_pkg::po_entry_t'($random(seed)), 1'b1, 1'b1);
        write_entry(2'd2, 2'd3, addr_pkg::po_entry_t'($random(seed)), 1'b0, 1'b0);
        repeat (2) issue_access(window_addr(2'd3), 2'd2);
        drain_and_compare();
    endtask

    task automatic test_write_priority();
        write_entry(2'd1, 2'd0, {1'b0, 3'd4, addr_pkg::addr_t'($random(seed))});
        issue_access(window_addr(2'd0), 2'd1);
        issue_access(direct_addr(), 2'd1);
        // Lands in the write-back cycle of the indirect access
        p_po_wren = 1'b1;
        p_po_idx  = 2'd0;
        p_po_data = {1'b1, 3'd1, addr_pkg::addr_t'($random(seed))};
        p_po_rdy  = 1'b1;
        p_po_cncl = 1'b0;
        issue_access(direct_addr(), 2'd1);
        repeat (2) issue_access(window_addr(2'd0), 2'd1);
        drain_and_compare();
    endtask

    task automatic test_thread_isolation();
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            write_entry(thread_pkg::thread_t'(t), 2'd2, addr_pkg::po_entry_t'($random(seed)));
        end
        for (int i = 0; i < 24; i++) begin
            issue_access(window_addr(2'd2), thread_pkg::thread_t'($random(seed)));
        end
        drain_and_compare();
    endtask

    //----------------------------------------------------------
    // Sequence and result
    //----------------------------------------------------------

    initial begin
        arst_n = 1'b0;
        {raw_addr, read_thread, write_thread, io_ready_current, cancel_current} = '0;
        {po_wren, po_write_index, po_write_data, io_ready_previous, cancel_previous} = '0;
        {do_wren, do_write_data} = '0;
        {p_po_wren, p_po_rdy, p_po_cncl, p_do_wren, p_po_idx, p_po_data, p_do_data} = '0;
        for (int i = 0; i < 4; i++) slots[i] = '0;
        for (int a = 0; a < RAM_DEPTH; a++) ram_known[a] = 1'b0;
        for (int t = 0; t < `THREAD_COUNT; t++) do_model[t] = '0;
        repeat (3) @(posedge clock);
        #1 arst_n = 1'b1;
        test_direct();
        test_indirect_read();
        test_post_increment();
        test_masking();
        test_write_priority();
        test_thread_isolation();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // About 215 cycles of tests plus margin
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/addr_pkg.sv
design/thread_pkg.sv
design/po_write_if.sv
design/po_memory.sv
design/default_offset_memory.sv
design/address_translator.sv
design/address_module.sv
bench/address_module_assert.sv
bench/address_module_tb.sv

//--- Bender.yml
package:
  name: address_module

sources:
  - include_dirs:
      - design
    files:
      - design/addr_pkg.sv
      - design/thread_pkg.sv
      - design/po_write_if.sv
      - design/po_memory.sv
      - design/default_offset_memory.sv
      - design/address_translator.sv
      - design/address_module.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/address_module_assert.sv
      - bench/address_module_tb.sv
